// File: common/l2_cache_pkg.sv
`default_nettype none

package l2_cache_pkg;

    // processor side widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // fixed 8-way tree
    localparam int NUM_WAYS = 8;
    localparam int WAY_W = 3;

    // byte address, bits 1..0 ignored, then set, then tag
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WAY_W-1:0] way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_RD,
        FILL,
        MEM_WR,
        RESP
    } ctrl_state_e;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    // held stable by the controller until ack
    typedef struct packed {
        logic valid;
        mem_op_e op;
        addr_t addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // ack is a single-cycle pulse
    typedef struct packed {
        logic ack;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic hit;
        way_t way;
    } lookup_t;

endpackage

`default_nettype wire

// File: l2_cache/l2_plru.sv
`timescale 1ns/1ps
`default_nettype none

module l2_plru import l2_cache_pkg::*; #(
    parameter int SET_W = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             touch_i,
    input  logic [SET_W-1:0] set_i,
    input  way_t             way_i,
    output way_t             victim_o
);

    // tree nodes in heap order: 0 root, 1..2 middle, 3..6 leaves
    // children of node i are 2i+1 (left) and 2i+2 (right)
    logic [6:0] node_en;
    logic [6:0] node_bit;

    // a touch always starts at the root
    assign node_en[0] = touch_i;

    for (genvar i = 0; i < 7; i++) begin : g_node
        // root stores way bit 2, middle bit 1, leaves bit 0
        localparam int LVL = (i == 0) ? 0 : ((i < 3) ? 1 : 2);

        if (i < 3) begin : g_inner
            // inner node passes the enable down the touched path
            l2_plru_node #(
                .SET_W(SET_W)
            ) u_node (
                .clk_i       (clk_i),
                .rst_ni      (rst_ni),
                .valid_i     (node_en[i]),
                .set_i       (set_i),
                .value_i     (way_i[WAY_W-1-LVL]),
                .load_left_o (node_en[2*i+1]),
                .load_right_o(node_en[2*i+2]),
                .bit_o       (node_bit[i])
            );
        end else begin : g_leaf
            // leaves have no children
            l2_plru_node #(
                .SET_W(SET_W)
            ) u_node (
                .clk_i       (clk_i),
                .rst_ni      (rst_ni),
                .valid_i     (node_en[i]),
                .set_i       (set_i),
                .value_i     (way_i[WAY_W-1-LVL]),
                .load_left_o (),
                .load_right_o(),
                .bit_o       (node_bit[i])
            );
        end
    end

    // victim walks away from the recent path
    always_comb begin
        victim_o[2] = ~node_bit[0];
        victim_o[1] = victim_o[2] ? ~node_bit[2] : ~node_bit[1];
        // leaf index = 3 + upper two victim bits
        victim_o[0] = ~node_bit[3 + victim_o[2:1]];
    end

endmodule

module l2_plru_node #(
    parameter int SET_W = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             valid_i,
    input  logic [SET_W-1:0] set_i,
    input  logic             value_i,
    output logic             load_left_o,
    output logic             load_right_o,
    output logic             bit_o
);

    // one direction bit per set
    logic [(1<<SET_W)-1:0] bits_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            bits_q <= '0;
        end else if (valid_i) begin
            bits_q[set_i] <= value_i;
        end
    end

    // enable only the child on the touched side
    assign load_left_o  = valid_i & ~value_i;
    assign load_right_o = valid_i & value_i;
    assign bit_o        = bits_q[set_i];

endmodule

`default_nettype wire

// File: l2_cache/l2_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tag_array import l2_cache_pkg::*; #(
    parameter int SET_W = 4
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  addr_t   addr_i,
    input  logic    fill_i,
    input  way_t    fill_way_i,
    output lookup_t lookup_o
);

    localparam int NUM_SETS = 1 << SET_W;
    localparam int TAG_W = ADDR_W - SET_W - 2;

    logic [SET_W-1:0] set_idx;
    logic [TAG_W-1:0] tag;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] hit_vec;

    // word address split into set and tag
    assign set_idx = addr_i[SET_W+1:2];
    assign tag     = addr_i[ADDR_W-1:SET_W+2];

    // compare all ways of the set at once, then encode
    always_comb begin
        lookup_o.way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == tag);
            if (hit_vec[w]) lookup_o.way = way_t'(w);
        end
        lookup_o.hit = |hit_vec;
    end

    // valid bits start clear
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[set_idx][fill_way_i] <= 1'b1;
        end
    end

    // tag storage, qualified by valid
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[set_idx][fill_way_i] <= tag;
        end
    end

    // fills only go to missing addresses, so a tag lives in one way
    a_one_hit: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_vec)
    );

endmodule

`default_nettype wire

// File: l2_cache/l2_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module l2_data_array import l2_cache_pkg::*; #(
    parameter int SET_W = 4
) (
    input  logic              clk_i,
    input  addr_t             addr_i,
    input  way_t              way_i,
    input  logic              we_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o
);

    localparam int NUM_SETS = 1 << SET_W;

    logic [SET_W-1:0] set_idx;
    // one word per line
    logic [DATA_W-1:0] mem_q [NUM_SETS][NUM_WAYS];

    assign set_idx = addr_i[SET_W+1:2];

    // write at the edge, read and write share the way select
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[set_idx][way_i] <= wdata_i;
        end
    end

    // combinational read
    assign rdata_o = mem_q[set_idx][way_i];

endmodule

`default_nettype wire

// File: l2_cache/l2_cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_ctrl import l2_cache_pkg::*; #(
    parameter int SET_W = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  addr_t             paddr_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    input  lookup_t           lookup_i,
    input  logic [DATA_W-1:0] hit_data_i,
    input  way_t              victim_i,
    output logic              tag_fill_o,
    output way_t              fill_way_o,
    output logic              data_we_o,
    output way_t              data_way_o,
    output logic [DATA_W-1:0] data_o,
    output logic              plru_touch_o,
    output way_t              touch_way_o,
    output mem_req_t          mem_req_o,
    input  mem_rsp_t          mem_rsp_i
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic hit_q;
    way_t way_q;
    way_t victim_q;
    logic [DATA_W-1:0] rdata_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            // wait for the access phase
            IDLE: if (psel_i && penable_i) state_d = LOOKUP;
            // writes always go through, reads only on miss
            LOOKUP: begin
                if (pwrite_i) state_d = MEM_WR;
                else if (lookup_i.hit) state_d = RESP;
                else state_d = MEM_RD;
            end
            MEM_RD: if (mem_rsp_i.ack) state_d = FILL;
            FILL: state_d = RESP;
            MEM_WR: if (mem_rsp_i.ack) state_d = RESP;
            RESP: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP) hit_q <= lookup_i.hit;
        end
    end

    // hit way, victim and read word
    always_ff @(posedge clk_i) begin
        if (state_q == LOOKUP) begin
            way_q   <= lookup_i.way;
            rdata_q <= hit_data_i;
        end
        // victim frozen as the miss starts
        if (state_q == LOOKUP && state_d == MEM_RD) victim_q <= victim_i;
        if (state_q == MEM_RD && mem_rsp_i.ack) rdata_q <= mem_rsp_i.rdata;
    end

    assign pready_o = (state_q == RESP);
    assign prdata_o = rdata_q;

    // memory request, APB holds paddr and pwdata for us
    assign mem_req_o.valid = (state_q == MEM_RD) || (state_q == MEM_WR);
    assign mem_req_o.op    = (state_q == MEM_WR) ? MEM_WRITE : MEM_READ;
    assign mem_req_o.addr  = paddr_i;
    assign mem_req_o.wdata = pwdata_i;

    // fill goes to the latched victim
    assign tag_fill_o = (state_q == FILL);
    assign fill_way_o = victim_q;

    // live hit way during lookup so the word can be captured
    always_comb begin
        if (state_q == LOOKUP) data_way_o = lookup_i.way;
        else if (state_q == FILL) data_way_o = victim_q;
        else data_way_o = way_q;
    end

    // fill writes the memory word, write hit the APB word
    assign data_we_o = (state_q == FILL) || (state_q == RESP && hit_q && pwrite_i);
    assign data_o    = (state_q == FILL) ? rdata_q : pwdata_i;

    // recency on every hit and every fill
    assign plru_touch_o = (state_q == FILL) || (state_q == RESP && hit_q);
    assign touch_way_o  = (state_q == FILL) ? victim_q : way_q;

    a_req_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.valid && !mem_rsp_i.ack |=> mem_req_o.valid && $stable(mem_req_o)
    );

    // pready only inside an APB access phase
    a_pready_resp: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        pready_o |-> (state_q == RESP) && psel_i && penable_i
    );

    // tag array still misses on the filling address
    a_fill_no_hit: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        tag_fill_o |-> !lookup_i.hit
    );

    // arrays index by paddr, so the set must hold during the access
    a_set_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (state_q != IDLE) |-> $stable(paddr_i[SET_W+1:2])
    );

endmodule

`default_nettype wire

// File: l2_cache/l2_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top import l2_cache_pkg::*; #(
    parameter int SET_W = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  addr_t             paddr_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    output mem_req_t          mem_req_o,
    input  mem_rsp_t          mem_rsp_i
);

    lookup_t lookup;
    logic [DATA_W-1:0] hit_data;
    logic [DATA_W-1:0] data_wr;
    way_t victim;
    way_t fill_way;
    way_t data_way;
    way_t touch_way;
    logic tag_fill;
    logic data_we;
    logic plru_touch;

    l2_cache_ctrl #(
        .SET_W(SET_W)
    ) u_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .lookup_i    (lookup),
        .hit_data_i  (hit_data),
        .victim_i    (victim),
        .tag_fill_o  (tag_fill),
        .fill_way_o  (fill_way),
        .data_we_o   (data_we),
        .data_way_o  (data_way),
        .data_o      (data_wr),
        .plru_touch_o(plru_touch),
        .touch_way_o (touch_way),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i)
    );

    l2_tag_array #(
        .SET_W(SET_W)
    ) u_tag (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .addr_i    (paddr_i),
        .fill_i    (tag_fill),
        .fill_way_i(fill_way),
        .lookup_o  (lookup)
    );

    l2_data_array #(
        .SET_W(SET_W)
    ) u_data (
        .clk_i  (clk_i),
        .addr_i (paddr_i),
        .way_i  (data_way),
        .we_i   (data_we),
        .wdata_i(data_wr),
        .rdata_o(hit_data)
    );

    // pLRU takes the set field of paddr
    l2_plru #(
        .SET_W(SET_W)
    ) u_plru (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .touch_i (plru_touch),
        .set_i   (paddr_i[SET_W+1:2]),
        .way_i   (touch_way),
        .victim_o(victim)
    );

endmodule

`default_nettype wire

// File: sim/l2_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model import l2_cache_pkg::*; #(
    parameter logic [DATA_W-1:0] XOR_KEY = 32'h5a5a_c3c3
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  mem_req_t req_i,
    output mem_rsp_t rsp_o
);

    // words written so far, keyed by word address
    logic [DATA_W-1:0] written [addr_t];
    int seed;
    logic busy_q;
    logic [1:0] wait_q;
    addr_t word_addr;

    initial seed = 93945;

    assign word_addr = {req_i.addr[ADDR_W-1:2], 2'b00};

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            wait_q <= '0;
            rsp_o  <= '0;
        end else begin
            rsp_o.ack <= 1'b0;
            // no restart while the last ack is still visible
            if (req_i.valid && !busy_q && !rsp_o.ack) begin
                busy_q <= 1'b1;
                // 1 to 4 cycles of latency
                wait_q <= 2'($random(seed));
            end else if (busy_q) begin
                if (wait_q == 2'd0) begin
                    busy_q    <= 1'b0;
                    rsp_o.ack <= 1'b1;
                    if (req_i.op == MEM_WRITE) begin
                        written[word_addr] = req_i.wdata;
                    end else if (written.exists(word_addr)) begin
                        rsp_o.rdata <= written[word_addr];
                    end else begin
                        // untouched words are address xor key
                        rsp_o.rdata <= word_addr ^ XOR_KEY;
                    end
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache import l2_cache_pkg::*; ();

    localparam int SET_W = 4;
    localparam int NUM_SETS = 1 << SET_W;
    localparam int TAG_W = ADDR_W - SET_W - 2;
    localparam logic [DATA_W-1:0] XOR_KEY = 32'h5a5a_c3c3;
    // 40 accesses of up to 8 cycles at 4 ns, doubled
    localparam int WATCHDOG_NS = 40 * (2 + 4 + 2) * 4 * 2;

    logic clk;
    logic rst_n;
    addr_t paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic pready;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    int errors;
    int accesses;
    int ack_count;
    way_t exp_victim;

    // shadow cache state per set
    logic [TAG_W-1:0] sh_tag [NUM_SETS][NUM_WAYS];
    logic sh_valid [NUM_SETS][NUM_WAYS];
    logic [6:0] sh_tree [NUM_SETS];
    logic [DATA_W-1:0] sh_mem [addr_t];

    l2_cache_top #(
        .SET_W(SET_W)
    ) dut_i (
        .clk_i    (clk),
        .rst_ni   (rst_n),
        .paddr_i  (paddr),
        .psel_i   (psel),
        .penable_i(penable),
        .pwrite_i (pwrite),
        .pwdata_i (pwdata),
        .prdata_o (prdata),
        .pready_o (pready),
        .mem_req_o(mem_req),
        .mem_rsp_i(mem_rsp)
    );

    l2_mem_model #(
        .XOR_KEY(XOR_KEY)
    ) u_mem (
        .clk_i (clk),
        .rst_ni(rst_n),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the cache stopped answering");
        $display("Verification failed");
        $finish;
    end

    // ack is one cycle wide, so one negedge per request
    always @(negedge clk) begin
        if (rst_n && mem_rsp.ack) ack_count++;
    end

    a_quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !psel |-> !pready && !mem_req.valid)
    else begin
        $display("pready or memory request active outside an APB transfer");
        errors++;
    end

    a_req_matches: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.valid |-> mem_req.addr == paddr && (mem_req.op == MEM_WRITE) == pwrite
            && (!pwrite || mem_req.wdata == pwdata))
    else begin
        $display("memory request does not match the APB access");
        errors++;
    end

    a_fill_way: assert property (@(posedge clk) disable iff (!rst_n)
        dut_i.tag_fill |-> dut_i.fill_way == exp_victim)
    else begin
        $display("fill went to a way other than the predicted victim");
        errors++;
    end

    // walk down against each stored direction
    function automatic way_t tree_victim(input logic [6:0] t);
        way_t v;
        int node;
        node = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            v[2-lvl] = ~t[node];
            node = 2 * node + (v[2-lvl] ? 2 : 1);
        end
        return v;
    endfunction

    // root gets bit 2, then bit 1, leaf bit 0
    function automatic logic [6:0] tree_touch(input logic [6:0] t, input way_t w);
        logic [6:0] r;
        int node;
        r = t;
        node = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            r[node] = w[2-lvl];
            node = 2 * node + (w[2-lvl] ? 2 : 1);
        end
        return r;
    endfunction

    function automatic lookup_t shadow_lookup(input addr_t a);
        lookup_t r;
        logic [SET_W-1:0] set;
        set = a[SET_W+1:2];
        r = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (sh_valid[set][w] && sh_tag[set][w] == a[ADDR_W-1:SET_W+2]) begin
                r.hit = 1'b1;
                r.way = way_t'(w);
            end
        end
        return r;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set);
        return {tag[TAG_W-1:0], set[SET_W-1:0], 2'b00};
    endfunction

    task automatic compare_word(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        assert (act == exp)
        else begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the last one
    task automatic apb_transfer(input logic wr, input addr_t a, input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata, output int waits);
        paddr = a;
        pwrite = wr;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1 penable = 1'b1;
        waits = 0;
        // pready sampled mid-cycle
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic do_access(input string name, input logic wr, input addr_t a,
                             input logic [DATA_W-1:0] wdata);
        lookup_t look;
        logic [SET_W-1:0] set;
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] exp_data;
        int acks_before;
        int waits;
        set = a[SET_W+1:2];
        look = shadow_lookup(a);
        exp_victim = tree_victim(sh_tree[set]);
        acks_before = ack_count;
        apb_transfer(wr, a, wdata, rdata, waits);
        accesses++;
        if (wr) begin
            // write-through, no allocate on miss
            sh_mem[a] = wdata;
            compare_word({name, " requests"}, 32'd1, 32'(ack_count - acks_before));
            if (look.hit) sh_tree[set] = tree_touch(sh_tree[set], look.way);
        end else begin
            exp_data = sh_mem.exists(a) ? sh_mem[a] : (a ^ XOR_KEY);
            compare_word({name, " rdata"}, exp_data, rdata);
            if (look.hit) begin
                compare_word({name, " requests"}, 32'd0, 32'(ack_count - acks_before));
                compare_word({name, " latency"}, 32'd2, 32'(waits));
                sh_tree[set] = tree_touch(sh_tree[set], look.way);
            end else begin
                compare_word({name, " requests"}, 32'd1, 32'(ack_count - acks_before));
                sh_tag[set][exp_victim] = a[ADDR_W-1:SET_W+2];
                sh_valid[set][exp_victim] = 1'b1;
                sh_tree[set] = tree_touch(sh_tree[set], exp_victim);
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        errors = 0;
        accesses = 0;
        ack_count = 0;
        exp_victim = '0;
        // reset state, all lines invalid and all tree bits 0
        for (int s = 0; s < NUM_SETS; s++) begin
            sh_tree[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_tag[s][w] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        compare_word("reset_pready", 32'd0, {31'd0, pready});
        compare_word("reset_req_valid", 32'd0, {31'd0, mem_req.valid});

        do_access("read_miss", 1'b0, make_addr(1, 3), '0);
        do_access("read_hit", 1'b0, make_addr(1, 3), '0);
        do_access("write_hit", 1'b1, make_addr(1, 3), 32'hdead_beef);
        do_access("write_hit_read", 1'b0, make_addr(1, 3), '0);
        do_access("write_miss", 1'b1, make_addr(2, 3), 32'h1234_5678);
        do_access("write_miss_read", 1'b0, make_addr(2, 3), '0);

        // nine tags in set 5, the ninth evicts
        for (int i = 0; i < 9; i++) do_access("fill", 1'b0, make_addr(16 + i, 5), '0);
        for (int i = 0; i < 9; i++) do_access("reread", 1'b0, make_addr(16 + i, 5), '0);

        // set 6 traffic, then set 5 must be unchanged
        for (int i = 0; i < 4; i++) do_access("other_set", 1'b0, make_addr(40 + i, 6), '0);
        for (int i = 6; i < 9; i++) do_access("isolation", 1'b0, make_addr(16 + i, 5), '0);
        // new tag in set 5 misses, so its fill checks the set 5 victim
        do_access("isolation_victim", 1'b0, make_addr(25, 5), '0);

        repeat (2) @(posedge clk);
        $display("summary: %0d errors in %0d accesses", errors, accesses);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
common/l2_cache_pkg.sv
l2_cache/l2_plru.sv
l2_cache/l2_tag_array.sv
l2_cache/l2_data_array.sv
l2_cache/l2_cache_ctrl.sv
l2_cache/l2_cache_top.sv
sim/l2_mem_model.sv
sim/tb_l2_cache.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_l2_cache -o tb_l2_cache

out=$(./obj_dir/tb_l2_cache)
echo "$out"
echo "$out" | grep -qx "Verification passed"
